//--- compile.f
+incdir+src
src/wb_pkg.sv
src/wb_buffer.sv
src/wb_arbiter.sv
src/writeback.sv
tests/wb_checker.sv
tests/wb_monitor.sv
tests/writeback_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the writeback testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f compile.f \
    --top-module writeback_tb \
    -o writeback_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/writeback_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

//--- tests/writeback_tb.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

module writeback_tb;

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 20; // Test 1 length
    localparam int SHORT_GAP    = 4;  // Idle after each directed strobe
    localparam int NUM_BURSTS   = 40;
    localparam int MAX_BURST    = 6;  // Keeps each buffer under its depth
    localparam int DRAIN_GAP    = 16;
    // Five directed strobes, each followed by a gap plus the drain check cycles
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 3
                                + 5 * (1 + SHORT_GAP + 2)
                                + NUM_BURSTS * (MAX_BURST + DRAIN_GAP + 2);
    localparam int CYCLE_LIMIT  = TOTAL_CYCLES * 3 / 2;

    logic                     CLK;
    logic                     nRST;
    logic                     alu_done;
    logic [`WB_REG_BITS-1:0]  alu_reg_sel;
    logic [`WB_DATA_BITS-1:0] alu_wdat;
    logic                     load_done;
    logic [`WB_REG_BITS-1:0]  load_reg_sel;
    logic [`WB_DATA_BITS-1:0] load_wdat;
    logic                     jump_done;
    logic [`WB_REG_BITS-1:0]  jump_reg_sel;
    logic [`WB_DATA_BITS-1:0] jump_wdat;
    wb_pkg::wb_entry_t        wb_out;
    logic                     drain_check;
    int                       mon_errors;

    logic [31:0] rng_state;
    int cycle_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int test_num     = 0;
    int start_errors = 0;

    writeback dut (
        .CLK          (CLK),
        .nRST         (nRST),
        .alu_done     (alu_done),
        .alu_reg_sel  (alu_reg_sel),
        .alu_wdat     (alu_wdat),
        .load_done    (load_done),
        .load_reg_sel (load_reg_sel),
        .load_wdat    (load_wdat),
        .jump_done    (jump_done),
        .jump_reg_sel (jump_reg_sel),
        .jump_wdat    (jump_wdat),
        .wb_out       (wb_out)
    );

    wb_monitor mon (
        .CLK          (CLK),
        .nRST         (nRST),
        .alu_done     (alu_done),
        .alu_reg_sel  (alu_reg_sel),
        .alu_wdat     (alu_wdat),
        .load_done    (load_done),
        .load_reg_sel (load_reg_sel),
        .load_wdat    (load_wdat),
        .jump_done    (jump_done),
        .jump_reg_sel (jump_reg_sel),
        .jump_wdat    (jump_wdat),
        .wb_out       (wb_out),
        .drain_check  (drain_check),
        .errors       (mon_errors)
    );

    always #4 CLK = ~CLK; // 8 ns period

    // Watchdog
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic advance_rng(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // One cycle of strobes with fresh random payloads
    task automatic drive(input logic a, input logic l, input logic j);
        logic [31:0] r;
        @(negedge CLK);
        alu_done  = a;
        load_done = l;
        jump_done = j;
        advance_rng(r);
        alu_reg_sel  = r[4:0];
        load_reg_sel = r[12:8];
        jump_reg_sel = r[20:16];
        advance_rng(r);
        alu_wdat = r;
        advance_rng(r);
        load_wdat = r;
        advance_rng(r);
        jump_wdat = r;
    endtask

    // n idle cycles, the model must be empty after the last one
    task automatic settle(input int n);
        repeat (n - 1) begin
            @(negedge CLK);
            alu_done  = 1'b0;
            load_done = 1'b0;
            jump_done = 1'b0;
        end
        @(negedge CLK);
        alu_done    = 1'b0;
        load_done   = 1'b0;
        jump_done   = 1'b0;
        drain_check = 1'b1;
        @(negedge CLK);
        drain_check = 1'b0;
    endtask

    task automatic report_test(input string name);
        test_num = test_num + 1;
        if (mon_errors == start_errors) begin
            tests_passed = tests_passed + 1;
            $display("test %0d %s: ok", test_num, name);
        end
        else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     mon_errors - start_errors);
        end
        start_errors = mon_errors;
    endtask

    initial begin : main
        logic [31:0] r;
        int          len;
        CLK          = 1'b0;
        nRST         = 1'b0;
        alu_done     = 1'b0;
        alu_reg_sel  = '0;
        alu_wdat     = '0;
        load_done    = 1'b0;
        load_reg_sel = '0;
        load_wdat    = '0;
        jump_done    = 1'b0;
        jump_reg_sel = '0;
        jump_wdat    = '0;
        drain_check  = 1'b0;
        rng_state    = 32'h2039_0883;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        settle(IDLE_CYCLES);
        report_test("reset and idle");

        drive(1'b1, 1'b0, 1'b0);
        settle(SHORT_GAP);
        drive(1'b0, 1'b1, 1'b0);
        settle(SHORT_GAP);
        drive(1'b0, 1'b0, 1'b1);
        settle(SHORT_GAP);
        report_test("single-source bypass");

        drive(1'b0, 1'b1, 1'b1);
        settle(SHORT_GAP);
        report_test("jump with load");

        drive(1'b1, 1'b1, 1'b0);
        settle(SHORT_GAP);
        report_test("ALU and load together");

        for (int b = 0; b < NUM_BURSTS; b++) begin
            advance_rng(r);
            len = int'(r % 32'd6) + 1;
            for (int c = 0; c < len; c++) begin
                advance_rng(r);
                drive(r[0], r[1], r[2] & ~r[0]); // Never jump with ALU
            end
            settle(DRAIN_GAP);
        end
        report_test("random bursts");

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, mon_errors);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tests/wb_monitor.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

// Reference model of the writeback rules, compared against wb_out each cycle
module wb_monitor (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     alu_done,
    input  logic [`WB_REG_BITS-1:0]  alu_reg_sel,
    input  logic [`WB_DATA_BITS-1:0] alu_wdat,
    input  logic                     load_done,
    input  logic [`WB_REG_BITS-1:0]  load_reg_sel,
    input  logic [`WB_DATA_BITS-1:0] load_wdat,
    input  logic                     jump_done,
    input  logic [`WB_REG_BITS-1:0]  jump_reg_sel,
    input  logic [`WB_DATA_BITS-1:0] jump_wdat,
    input  wb_pkg::wb_entry_t        wb_out,
    input  logic                     drain_check, // DUT and model must both be empty now
    output int                       errors
);

    wb_pkg::wb_entry_t alu_q[$];  // Parked ALU results, oldest first
    wb_pkg::wb_entry_t load_q[$]; // Parked load results
    logic turn_alu;               // Model flag, 1 means ALU goes next
    int   err_count = 0;
    int   cycle     = 0;

    assign errors = err_count;

    function automatic wb_pkg::wb_entry_t make_entry(input logic [`WB_REG_BITS-1:0]  sel,
                                                      input logic [`WB_DATA_BITS-1:0] dat);
        wb_pkg::wb_entry_t e;
        e.reg_en  = 1'b1;
        e.reg_sel = sel;
        e.wdat    = dat;
        return e;
    endfunction

    always @(posedge CLK) begin : model_step
        wb_pkg::wb_entry_t alu_e;
        wb_pkg::wb_entry_t load_e;
        wb_pkg::wb_entry_t exp_e;
        logic              mismatch;
        cycle = cycle + 1;
        if (!nRST) begin
            alu_q.delete();
            load_q.delete();
            turn_alu = 1'b0; // Load first after reset
        end
        else begin
            alu_e  = make_entry(alu_reg_sel, alu_wdat);
            load_e = make_entry(load_reg_sel, load_wdat);
            exp_e  = '0;
            if (jump_done) begin
                exp_e = make_entry(jump_reg_sel, jump_wdat);
                if (load_done) load_q.push_back(load_e); // Load parked behind the jump
            end
            else if (alu_q.size() == 0 && load_q.size() == 0) begin
                if (alu_done && load_done) begin
                    exp_e = load_e;
                    alu_q.push_back(alu_e);
                end
                else if (alu_done) exp_e = alu_e;
                else if (load_done) exp_e = load_e;
            end
            else begin
                // Pop before push, a read sees the head from before this cycle
                if (alu_q.size() != 0 && load_q.size() != 0) begin
                    if (turn_alu) exp_e = alu_q.pop_front();
                    else exp_e = load_q.pop_front();
                    turn_alu = !turn_alu;
                end
                else if (alu_q.size() != 0) exp_e = alu_q.pop_front();
                else exp_e = load_q.pop_front();
                if (alu_done) alu_q.push_back(alu_e);
                if (load_done) load_q.push_back(load_e);
            end

            // Only reg_en matters when no write is expected
            if (exp_e.reg_en) mismatch = (wb_out !== exp_e);
            else mismatch = (wb_out.reg_en !== 1'b0);
            if (mismatch) begin
                $display("CHECK FAILED wb_out cycle %0d: reg_en=%h reg_sel=%h wdat=%h,",
                         cycle, wb_out.reg_en, wb_out.reg_sel, wb_out.wdat,
                         " expected reg_en=%h reg_sel=%h wdat=%h",
                         exp_e.reg_en, exp_e.reg_sel, exp_e.wdat);
                err_count = err_count + 1;
            end

            // Idle cycle after the gap, a DUT with nothing parked sends nothing
            if (drain_check && (wb_out.reg_en !== 1'b0 || alu_q.size() != 0
                                || load_q.size() != 0)) begin
                $display("Buffers not drained at cycle %0d: reg_en=%h, %0d ALU, %0d load left",
                         cycle, wb_out.reg_en, alu_q.size(), load_q.size());
                err_count = err_count + 1;
            end
        end
    end

endmodule

//--- tests/wb_checker.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

// Protocol assertions on both park buffers and the caller strobes
module wb_checker (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    alu_write,  // ALU buffer write strobe
    input logic                    alu_read,   // ALU buffer read strobe
    input logic                    alu_empty,
    input logic [`WB_CNT_BITS-1:0] alu_count,  // ALU buffer occupancy
    input logic                    load_write,
    input logic                    load_read,
    input logic                    load_empty,
    input logic [`WB_CNT_BITS-1:0] load_count, // Load buffer occupancy
    input logic                    jump_done,
    input logic                    alu_done
);

    alu_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        alu_write |-> (alu_count != `WB_CNT_BITS'(`WB_BUF_DEPTH)))
        else $error("ALU buffer written while full");

    load_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        load_write |-> (load_count != `WB_CNT_BITS'(`WB_BUF_DEPTH)))
        else $error("load buffer written while full");

    alu_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        alu_read |-> !alu_empty)
        else $error("ALU buffer read while empty");

    load_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        load_read |-> !load_empty)
        else $error("load buffer read while empty");

    // Callers never finish a jump and an ALU op together
    no_jump_alu: assert property (@(posedge CLK) disable iff (!nRST)
        !(jump_done && alu_done))
        else $error("jump_done and alu_done high in the same cycle");

endmodule

// Top level instance, occupancy taken from inside each buffer
bind writeback wb_checker u_chk (
    .CLK        (CLK),
    .nRST       (nRST),
    .alu_write  (alu_write),
    .alu_read   (alu_read),
    .alu_empty  (alu_empty),
    .alu_count  (u_alu_buf.count),
    .load_write (load_write),
    .load_read  (load_read),
    .load_empty (load_empty),
    .load_count (u_load_buf.count),
    .jump_done  (jump_done),
    .alu_done   (alu_done)
);

//--- src/writeback.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

// Writeback stage, one register write per cycle from ALU, load and jump
module writeback (
    input  logic                     CLK,
    input  logic                     nRST,
    // ALU result
    input  logic                     alu_done,
    input  logic [`WB_REG_BITS-1:0]  alu_reg_sel,
    input  logic [`WB_DATA_BITS-1:0] alu_wdat,
    // Load result
    input  logic                     load_done,
    input  logic [`WB_REG_BITS-1:0]  load_reg_sel,
    input  logic [`WB_DATA_BITS-1:0] load_wdat,
    // Jump link value
    input  logic                     jump_done,
    input  logic [`WB_REG_BITS-1:0]  jump_reg_sel,
    input  logic [`WB_DATA_BITS-1:0] jump_wdat,
    output wb_pkg::wb_entry_t        wb_out    // To register file
);

    // Incoming results as register writes
    wb_pkg::wb_entry_t alu_entry;
    wb_pkg::wb_entry_t load_entry;
    wb_pkg::wb_entry_t jump_entry;

    // Buffer side
    wb_pkg::wb_entry_t alu_head;
    wb_pkg::wb_entry_t load_head;
    logic              alu_empty;
    logic              load_empty;
    logic              alu_write;
    logic              load_write;
    logic              alu_read;
    logic              load_read;

    // reg_en set on every entry, the arbiter decides if it goes out
    assign alu_entry  = '{reg_en: 1'b1, reg_sel: alu_reg_sel,  wdat: alu_wdat};
    assign load_entry = '{reg_en: 1'b1, reg_sel: load_reg_sel, wdat: load_wdat};
    assign jump_entry = '{reg_en: 1'b1, reg_sel: jump_reg_sel, wdat: jump_wdat};

    // Parked ALU results
    wb_buffer u_alu_buf (
        .CLK      (CLK),
        .nRST     (nRST),
        .write    (alu_write),
        .wr_entry (alu_entry),
        .read     (alu_read),
        .head     (alu_head),
        .empty    (alu_empty)
    );

    // Parked load results
    wb_buffer u_load_buf (
        .CLK      (CLK),
        .nRST     (nRST),
        .write    (load_write),
        .wr_entry (load_entry),
        .read     (load_read),
        .head     (load_head),
        .empty    (load_empty)
    );

    wb_arbiter u_arb (
        .CLK        (CLK),
        .nRST       (nRST),
        .alu_done   (alu_done),
        .load_done  (load_done),
        .jump_done  (jump_done),
        .alu_entry  (alu_entry),
        .load_entry (load_entry),
        .jump_entry (jump_entry),
        .alu_head   (alu_head),
        .load_head  (load_head),
        .alu_empty  (alu_empty),
        .load_empty (load_empty),
        .alu_write  (alu_write),
        .load_write (load_write),
        .alu_read   (alu_read),
        .load_read  (load_read),
        .wb_out     (wb_out)
    );

endmodule

//--- src/wb_arbiter.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

// Chooses the single register write of each cycle
// Jump bypasses always, other results bypass only while nothing is parked
module wb_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              alu_done,
    input  logic              load_done,
    input  logic              jump_done,
    input  wb_pkg::wb_entry_t alu_entry,
    input  wb_pkg::wb_entry_t load_entry,
    input  wb_pkg::wb_entry_t jump_entry,
    input  wb_pkg::wb_entry_t alu_head,   // Oldest parked ALU result
    input  wb_pkg::wb_entry_t load_head,  // Oldest parked load result
    input  logic              alu_empty,
    input  logic              load_empty,
    output logic              alu_write,  // Park alu_entry
    output logic              load_write, // Park load_entry
    output logic              alu_read,   // Retire ALU head
    output logic              load_read,  // Retire load head
    output wb_pkg::wb_entry_t wb_out
);

    wb_pkg::wb_src_t src; // Output source this cycle

    // Turn flag for two busy buffers
    // 1 means ALU goes next, 0 means load
    logic alt_sel;
    logic alt_sel_nxt;

    logic any_parked;     // At least one buffer holds data
    logic both_parked;    // Both buffers hold data

    assign any_parked  = !alu_empty || !load_empty;
    assign both_parked = !alu_empty && !load_empty;

    // Cycle rules, jump first, then the empty case, then buffered
    always_comb begin
        src         = wb_pkg::SRC_NONE;
        alu_write   = 1'b0;
        load_write  = 1'b0;
        alt_sel_nxt = alt_sel;

        if (jump_done) begin
            // Jump goes straight out
            src        = wb_pkg::SRC_JUMP;
            load_write = load_done; // A load finishing alongside is parked
            // ALU never finishes together with a jump
        end
        else if (!any_parked) begin
            // Nothing parked, bypass what we can
            if (alu_done && load_done) begin
                src       = wb_pkg::SRC_LOAD_IN;
                alu_write = 1'b1;   // ALU waits its turn in the buffer
            end
            else if (alu_done) begin
                src = wb_pkg::SRC_ALU_IN;
            end
            else if (load_done) begin
                src = wb_pkg::SRC_LOAD_IN;
            end
        end
        else begin
            // Something is parked
            // New results queue behind it so order per source holds
            alu_write  = alu_done;
            load_write = load_done;

            if (both_parked) begin
                // Take turns between buffers
                if (alt_sel) begin
                    src = wb_pkg::SRC_ALU_BUF;
                end
                else begin
                    src = wb_pkg::SRC_LOAD_BUF;
                end
                alt_sel_nxt = !alt_sel;
            end
            else if (!alu_empty) begin
                src = wb_pkg::SRC_ALU_BUF;  // Only ALU has data, flag holds
            end
            else begin
                src = wb_pkg::SRC_LOAD_BUF; // Only load has data, flag holds
            end
        end
    end

    // Retire a head whenever it is the output
    assign alu_read  = (src == wb_pkg::SRC_ALU_BUF);
    assign load_read = (src == wb_pkg::SRC_LOAD_BUF);

    // Output mux
    always_comb begin
        case (src)
            wb_pkg::SRC_JUMP:     wb_out = jump_entry;
            wb_pkg::SRC_ALU_IN:   wb_out = alu_entry;
            wb_pkg::SRC_LOAD_IN:  wb_out = load_entry;
            wb_pkg::SRC_ALU_BUF:  wb_out = alu_head;  // Head before this cycle's park
            wb_pkg::SRC_LOAD_BUF: wb_out = load_head;
            default:              wb_out = '0;        // No write, reg_en low
        endcase
    end

    // Alternation flag, load first after reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alt_sel <= 1'b0;
        end
        else begin
            alt_sel <= alt_sel_nxt;
        end
    end

endmodule

//--- src/wb_buffer.sv
`timescale 1ns/1ns
`include "wb_settings.svh"

// Circular park buffer for one result source
module wb_buffer (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              write,    // Park wr_entry this cycle
    input  wb_pkg::wb_entry_t wr_entry,
    input  logic              read,     // Retire head this cycle
    output wb_pkg::wb_entry_t head,     // Oldest parked entry
    output logic              empty
);

    // Last slot index, pointers wrap after it
    localparam logic [`WB_PTR_BITS-1:0] LAST_SLOT = `WB_PTR_BITS'(`WB_BUF_DEPTH - 1);

    // Entry storage
    wb_pkg::wb_entry_t mem [`WB_BUF_DEPTH];

    logic [`WB_PTR_BITS-1:0] wr_ptr;      // Next free slot
    logic [`WB_PTR_BITS-1:0] rd_ptr;      // Oldest entry
    logic [`WB_CNT_BITS-1:0] count;       // Entries held
    logic [`WB_PTR_BITS-1:0] wr_ptr_nxt;
    logic [`WB_PTR_BITS-1:0] rd_ptr_nxt;
    logic [`WB_CNT_BITS-1:0] count_nxt;

    // Pointer advance with wrap
    always_comb begin
        wr_ptr_nxt = wr_ptr;
        rd_ptr_nxt = rd_ptr;
        if (write) begin
            wr_ptr_nxt = (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
        end
        if (read) begin
            rd_ptr_nxt = (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
        end
    end

    // Occupancy
    always_comb begin
        count_nxt = count; // Write and read together leave it unchanged
        if (write && !read) begin
            count_nxt = count + 1'b1;
        end
        else if (read && !write) begin
            count_nxt = count - 1'b1;
        end
    end

    // Payload write at the current write pointer
    always_ff @(posedge CLK) begin
        if (write) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            wr_ptr <= wr_ptr_nxt;
            rd_ptr <= rd_ptr_nxt;
            count  <= count_nxt;
        end
    end

    assign empty = (count == '0);
    assign head  = mem[rd_ptr]; // Still the old head during a same-cycle read

endmodule

//--- src/wb_pkg.sv
`include "wb_settings.svh"

package wb_pkg;

    // One register file write as it leaves writeback
    typedef struct packed {
        logic                     reg_en;  // Register file write enable
        logic [`WB_REG_BITS-1:0]  reg_sel; // Destination register
        logic [`WB_DATA_BITS-1:0] wdat;    // Value to write
    } wb_entry_t;

    // Where this cycle's output comes from
    // Inputs are bypassed, buffers are parked results
    typedef enum logic [2:0] {
        SRC_NONE     = 3'd0, // Idle, reg_en low
        SRC_JUMP     = 3'd1, // Jump link value, always bypassed
        SRC_ALU_IN   = 3'd2, // ALU result straight through
        SRC_LOAD_IN  = 3'd3, // Load result straight through
        SRC_ALU_BUF  = 3'd4, // Head of the ALU buffer
        SRC_LOAD_BUF = 3'd5  // Head of the load buffer
    } wb_src_t;

endpackage

//--- src/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Entries per park buffer
`define WB_BUF_DEPTH 8
// Register index width
`define WB_REG_BITS  5
// Register write data width
`define WB_DATA_BITS 32
`define WB_PTR_BITS  3   // Buffer slot index
`define WB_CNT_BITS  4   // Occupancy, 0 up to WB_BUF_DEPTH

`endif
